// File: Makefile
# Verilator build and run for the memory fabric testbench

VERILATOR  ?= verilator
TOP        ?= tb_soc_mem_fabric
RTL_TOP    ?= soc_mem_fabric
FILELIST   ?= files.f
BUILD_DIR  ?= build
LOG        ?= $(BUILD_DIR)/sim.log
VFLAGS     ?= --binary --timing
LINT_FLAGS ?= --lint-only -Wall
PASS_MSG   ?= All tests passed

RTL_SRCS   := $(shell grep '^logic/' $(FILELIST))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || { echo "simulation did not pass"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR)

// File: files.f
logic/soc_pkg.sv
logic/soc_reset_ctrl.sv
logic/mem_decoder.sv
logic/ram_bank.sv
logic/rsp_mux.sv
logic/soc_mem_fabric.sv
sim/tb_soc_mem_fabric.sv

// File: logic/mem_decoder.sv
`default_nettype none

module mem_decoder #(
  parameter  int unsigned NumBanks  = 4,
  parameter  int unsigned BankWords = 256,
  localparam int unsigned RowWidth  = $clog2(BankWords)
) (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           req_valid_i,
  input  soc_pkg::mem_req_t              req_i,
  output logic [NumBanks-1:0]            bank_sel_o,
  output logic [RowWidth-1:0]            row_o,
  output logic                           we_o,
  output logic [soc_pkg::BeWidth-1:0]    be_o,
  output logic [soc_pkg::DataWidth-1:0]  wdata_o,
  output soc_pkg::route_t                route_o
);

  import soc_pkg::*;

  localparam int unsigned WindowBytes = NumBanks * BankWords * BeWidth;

  logic [AddrWidth-1:0]                offset;
  logic [AddrWidth-WordOffsetBits-1:0] word_idx;
  logic                                mapped;
  logic [BankIdxWidth-1:0]             bank_idx;
  route_t                              route_q;

  // ----------------------------------------
  // Address map
  // ----------------------------------------
  assign offset   = req_i.addr - RamBase;
  assign mapped   = (req_i.addr >= RamBase) && (offset < AddrWidth'(WindowBytes));
  // Byte lane bits dropped
  assign word_idx = offset[AddrWidth-1:WordOffsetBits];
  assign bank_idx = BankIdxWidth'(word_idx / BankWords);
  assign row_o    = RowWidth'(word_idx % BankWords);

  always_comb begin
    for (int unsigned b = 0; b < NumBanks; b++) begin
      bank_sel_o[b] = req_valid_i && mapped && (bank_idx == BankIdxWidth'(b));
    end
  end

  // Broadcast to all banks
  assign we_o    = req_i.we;
  assign be_o    = req_i.be;
  assign wdata_o = req_i.wdata;

  // ----------------------------------------
  // Route record
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      route_q <= '0;
    end else begin
      route_q.valid <= req_valid_i;
      route_q.err   <= req_valid_i && !mapped;
      route_q.we    <= req_valid_i && req_i.we;
      route_q.bank  <= bank_idx;
    end
  end

  assign route_o = route_q;

endmodule

`default_nettype wire

// File: logic/ram_bank.sv
`default_nettype none

module ram_bank #(
  parameter  int unsigned BankWords = 256,
  localparam int unsigned RowWidth  = $clog2(BankWords)
) (
  input  logic                          clk_i,
  input  logic                          sel_i,
  input  logic                          we_i,
  input  logic [RowWidth-1:0]           row_i,
  input  logic [soc_pkg::BeWidth-1:0]   be_i,
  input  logic [soc_pkg::DataWidth-1:0] wdata_i,
  output logic [soc_pkg::DataWidth-1:0] rdata_o
);

  import soc_pkg::*;

  localparam int unsigned ByteWidth = DataWidth / BeWidth;

  logic [DataWidth-1:0] mem_q [BankWords];
  logic [DataWidth-1:0] rdata_q;

  // Byte-masked write, registered read
  always_ff @(posedge clk_i) begin
    if (sel_i) begin
      if (we_i) begin
        for (int unsigned i = 0; i < BeWidth; i++) begin
          if (be_i[i]) begin
            mem_q[row_i][i*ByteWidth +: ByteWidth] <= wdata_i[i*ByteWidth +: ByteWidth];
          end
        end
      end else begin
        rdata_q <= mem_q[row_i];
      end
    end
  end

  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

// File: logic/rsp_mux.sv
`default_nettype none

module rsp_mux #(
  parameter int unsigned NumBanks = 4
) (
  input  logic                                       clk_i,
  input  logic                                       rst_ni,
  input  soc_pkg::route_t                            route_i,
  input  logic [NumBanks-1:0][soc_pkg::DataWidth-1:0] bank_rdata_i,
  output logic                                       rsp_valid_o,
  output soc_pkg::mem_rsp_t                          rsp_o,
  output logic [soc_pkg::ErrCountWidth-1:0]          err_count_o
);

  import soc_pkg::*;

  mem_rsp_t                 rsp_d;
  mem_rsp_t                 rsp_q;
  logic                     rsp_valid_q;
  logic [ErrCountWidth-1:0] err_cnt_q;

  // ----------------------------------------
  // Bank select
  // ----------------------------------------
  // Writes and errors answer with zero data
  always_comb begin
    rsp_d.rdata = '0;
    rsp_d.err   = route_i.err;
    if (route_i.valid && !route_i.err && !route_i.we) begin
      for (int unsigned b = 0; b < NumBanks; b++) begin
        if (route_i.bank == BankIdxWidth'(b)) begin
          rsp_d.rdata = bank_rdata_i[b];
        end
      end
    end
  end

  // ----------------------------------------
  // Output stage and error count
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsp_valid_q <= 1'b0;
      err_cnt_q   <= '0;
    end else begin
      rsp_valid_q <= route_i.valid;
      // Saturates at all ones
      if (route_i.valid && route_i.err && (err_cnt_q != '1)) begin
        err_cnt_q <= err_cnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    rsp_q <= rsp_d;
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o       = rsp_q;
  assign err_count_o = err_cnt_q;

endmodule

`default_nettype wire

// File: logic/soc_mem_fabric.sv
`default_nettype none

module soc_mem_fabric #(
  parameter  int unsigned NumBanks        = 4,
  parameter  int unsigned BankWords       = 256,
  parameter  int unsigned DebugHoldCycles = 500,
  localparam int unsigned RowWidth        = $clog2(BankWords)
) (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              ndmreset_i,
  input  logic                              debug_enable_i,
  input  logic                              debug_req_i,
  input  logic                              req_valid_i,
  input  soc_pkg::mem_req_t                 req_i,
  output logic                              debug_req_o,
  output logic                              rsp_valid_o,
  output soc_pkg::mem_rsp_t                 rsp_o,
  output logic [soc_pkg::ErrCountWidth-1:0] err_count_o
);

  import soc_pkg::*;

  logic                               fabric_rst_n;
  logic [NumBanks-1:0]                bank_sel;
  logic [RowWidth-1:0]                row;
  logic                               we;
  logic [BeWidth-1:0]                 be;
  logic [DataWidth-1:0]               wdata;
  route_t                             route;
  logic [NumBanks-1:0][DataWidth-1:0] bank_rdata;

  // ----------------------------------------
  // Reset and debug housekeeping
  // ----------------------------------------
  soc_reset_ctrl #(
    .DebugHoldCycles ( DebugHoldCycles )
  ) i_reset_ctrl (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .ndmreset_i     ( ndmreset_i     ),
    .debug_enable_i ( debug_enable_i ),
    .debug_req_i    ( debug_req_i    ),
    .fabric_rst_no  ( fabric_rst_n   ),
    .debug_req_o    ( debug_req_o    )
  );

  // ----------------------------------------
  // Address decode
  // ----------------------------------------
  mem_decoder #(
    .NumBanks  ( NumBanks  ),
    .BankWords ( BankWords )
  ) i_decoder (
    .clk_i       ( clk_i        ),
    .rst_ni      ( fabric_rst_n ),
    .req_valid_i ( req_valid_i  ),
    .req_i       ( req_i        ),
    .bank_sel_o  ( bank_sel     ),
    .row_o       ( row          ),
    .we_o        ( we           ),
    .be_o        ( be           ),
    .wdata_o     ( wdata        ),
    .route_o     ( route        )
  );

  // ----------------------------------------
  // SRAM banks
  // ----------------------------------------
  for (genvar b = 0; b < NumBanks; b++) begin : gen_bank
    ram_bank #(
      .BankWords ( BankWords )
    ) i_bank (
      .clk_i   ( clk_i         ),
      .sel_i   ( bank_sel[b]   ),
      .we_i    ( we            ),
      .row_i   ( row           ),
      .be_i    ( be            ),
      .wdata_i ( wdata         ),
      .rdata_o ( bank_rdata[b] )
    );
  end

  // ----------------------------------------
  // Response path
  // ----------------------------------------
  rsp_mux #(
    .NumBanks ( NumBanks )
  ) i_rsp_mux (
    .clk_i        ( clk_i        ),
    .rst_ni       ( fabric_rst_n ),
    .route_i      ( route        ),
    .bank_rdata_i ( bank_rdata   ),
    .rsp_valid_o  ( rsp_valid_o  ),
    .rsp_o        ( rsp_o        ),
    .err_count_o  ( err_count_o  )
  );

endmodule

`default_nettype wire

// File: logic/soc_pkg.sv
`default_nettype none

package soc_pkg;

  // ----------------------------------------
  // Widths and address map
  // ----------------------------------------
  localparam int unsigned AddrWidth      = 32;
  localparam int unsigned DataWidth      = 64;
  localparam int unsigned BeWidth        = DataWidth / 8;
  localparam int unsigned WordOffsetBits = $clog2(BeWidth);
  localparam int unsigned ErrCountWidth  = 8;
  // Wide enough for up to 16 banks
  localparam int unsigned BankIdxWidth   = 4;

  localparam logic [AddrWidth-1:0] RamBase = 32'h8000_0000;

  // ----------------------------------------
  // Bus records
  // ----------------------------------------
  typedef struct packed {
    logic                 we;
    logic [AddrWidth-1:0] addr;
    logic [BeWidth-1:0]   be;
    logic [DataWidth-1:0] wdata;
  } mem_req_t;

  typedef struct packed {
    logic [DataWidth-1:0] rdata;
    logic                 err;
  } mem_rsp_t;

  // One entry per accepted request, one cycle behind it
  typedef struct packed {
    logic                    valid;
    logic                    err;
    logic                    we;
    logic [BankIdxWidth-1:0] bank;
  } route_t;

endpackage

`default_nettype wire

// File: logic/soc_reset_ctrl.sv
`default_nettype none

module soc_reset_ctrl #(
  parameter int unsigned DebugHoldCycles = 500
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic ndmreset_i,
  input  logic debug_enable_i,
  input  logic debug_req_i,
  output logic fabric_rst_no,
  output logic debug_req_o
);

  localparam int unsigned CntWidth =
    (DebugHoldCycles > 0) ? $clog2(DebugHoldCycles + 1) : 1;

  logic                comb_rst_n;
  logic [1:0]          sync_q;
  logic [CntWidth-1:0] hold_cnt_q;

  // ----------------------------------------
  // Fabric reset
  // ----------------------------------------
  // Asserts at once, releases after two edges
  assign comb_rst_n = rst_ni & ~ndmreset_i;

  always_ff @(posedge clk_i or negedge comb_rst_n) begin
    if (!comb_rst_n) begin
      sync_q <= '0;
    end else begin
      sync_q <= {sync_q[0], 1'b1};
    end
  end

  assign fabric_rst_no = sync_q[1];

  // ----------------------------------------
  // Debug request hold-off
  // ----------------------------------------
  // Only the power-on reset reloads the counter
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hold_cnt_q <= CntWidth'(DebugHoldCycles);
    end else if (hold_cnt_q != '0) begin
      hold_cnt_q <= hold_cnt_q - 1'b1;
    end
  end

  assign debug_req_o = (hold_cnt_q == '0) & debug_enable_i & debug_req_i;

endmodule

`default_nettype wire

// File: sim/tb_soc_mem_fabric.sv
`default_nettype none

module tb_soc_mem_fabric;

  import soc_pkg::*;

  localparam int unsigned NumBanks        = 4;
  localparam int unsigned BankWords       = 256;
  localparam int unsigned DebugHoldCycles = 20;
  localparam int unsigned Words           = NumBanks * BankWords;
  localparam int unsigned Timeout         = 20;

  logic                     clk_i;
  logic                     rst_ni;
  logic                     ndmreset_i;
  logic                     debug_enable_i;
  logic                     debug_req_i;
  logic                     req_valid_i;
  mem_req_t                 req_i;
  logic                     debug_req_o;
  logic                     rsp_valid_o;
  mem_rsp_t                 rsp_o;
  logic [ErrCountWidth-1:0] err_count_o;

  // Mirror of the RAM window
  logic [DataWidth-1:0] model [Words];
  int unsigned          written [$];
  int unsigned          err_expected;
  int unsigned          errors;
  int unsigned          test_errors;
  int unsigned          tests_run;
  int unsigned          tests_failed;

  soc_mem_fabric #(
    .NumBanks        ( NumBanks        ),
    .BankWords       ( BankWords       ),
    .DebugHoldCycles ( DebugHoldCycles )
  ) uut (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .ndmreset_i     ( ndmreset_i     ),
    .debug_enable_i ( debug_enable_i ),
    .debug_req_i    ( debug_req_i    ),
    .req_valid_i    ( req_valid_i    ),
    .req_i          ( req_i          ),
    .debug_req_o    ( debug_req_o    ),
    .rsp_valid_o    ( rsp_valid_o    ),
    .rsp_o          ( rsp_o          ),
    .err_count_o    ( err_count_o    )
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // ----------------------------------------
  // Helpers
  // ----------------------------------------
  // Drive and sample just after the rising edge
  task automatic step();
    @(posedge clk_i);
    #1;
  endtask

  function automatic logic [AddrWidth-1:0] word_addr(input int unsigned idx);
    return RamBase + AddrWidth'(idx * 8);
  endfunction

  task automatic check(input string name, input logic [63:0] expected,
                       input logic [63:0] actual);
    if (actual !== expected) begin
      $display("mismatch in %s: expected %h, actual %h", name, expected, actual);
      errors++;
      test_errors++;
    end
  endtask

  task automatic report_failure(input string name, input string msg);
    $display("error in %s: %s", name, msg);
    errors++;
    test_errors++;
  endtask

  task automatic start_test();
    test_errors = 0;
    tests_run++;
  endtask

  task automatic finish_test(input string name);
    if (test_errors == 0) begin
      $display("%s: ok", name);
    end else begin
      tests_failed++;
      $display("%s: %0d errors", name, test_errors);
    end
  endtask

  // One request, then wait for its response
  task automatic access(input string name, input logic we, input logic [AddrWidth-1:0] addr,
                        input logic [BeWidth-1:0] be, input logic [DataWidth-1:0] wdata,
                        output mem_rsp_t rsp, output logic got);
    int unsigned waited;
    req_valid_i = 1'b1;
    req_i.we    = we;
    req_i.addr  = addr;
    req_i.be    = be;
    req_i.wdata = wdata;
    step();
    req_valid_i = 1'b0;
    req_i       = '0;
    got         = 1'b0;
    rsp         = '0;
    waited      = 0;
    while (!got && waited < Timeout) begin
      step();
      waited++;
      if (rsp_valid_o) begin
        got = 1'b1;
        rsp = rsp_o;
      end
    end
    if (!got) begin
      report_failure(name, "no response from the DUT before the timeout");
    end
  endtask

  task automatic write_word(input string name, input int unsigned idx,
                            input logic [BeWidth-1:0] be, input logic [DataWidth-1:0] data);
    mem_rsp_t rsp;
    logic     got;
    access(name, 1'b1, word_addr(idx), be, data, rsp, got);
    if (got) begin
      check(name, 64'd0, 64'(rsp.err));
      check(name, 64'd0, rsp.rdata);
    end
    for (int unsigned i = 0; i < 8; i++) begin
      if (be[i]) begin
        model[idx][i*8 +: 8] = data[i*8 +: 8];
      end
    end
  endtask

  task automatic read_word(input string name, input int unsigned idx);
    mem_rsp_t rsp;
    logic     got;
    access(name, 1'b0, word_addr(idx), 8'h00, 64'd0, rsp, got);
    if (got) begin
      check(name, 64'd0, 64'(rsp.err));
      check(name, model[idx], rsp.rdata);
    end
  endtask

  task automatic expect_error(input string name, input logic we,
                              input logic [AddrWidth-1:0] addr);
    mem_rsp_t rsp;
    logic     got;
    access(name, we, addr, 8'hff, 64'hdead_beef_cafe_f00d, rsp, got);
    err_expected++;
    if (got) begin
      check(name, 64'd1, 64'(rsp.err));
      check(name, 64'd0, rsp.rdata);
    end
  endtask

  // ----------------------------------------
  // Tests
  // ----------------------------------------
  task automatic test_debug_holdoff();
    string name;
    name = "debug_holdoff";
    start_test();
    for (int unsigned e = 1; e <= 19; e++) begin
      step();
      check(name, 64'd0, 64'(debug_req_o));
    end
    repeat (2) step();
    check(name, 64'd1, 64'(debug_req_o));
    debug_enable_i = 1'b0;
    repeat (3) begin
      step();
      check(name, 64'd0, 64'(debug_req_o));
    end
    debug_enable_i = 1'b1;
    step();
    check(name, 64'd1, 64'(debug_req_o));
    check(name, 64'd0, 64'(rsp_valid_o));
    check(name, 64'd0, 64'(err_count_o));
    finish_test(name);
  endtask

  task automatic test_write_read();
    string       name;
    int unsigned idx;
    name = "write_read";
    start_test();
    for (int unsigned b = 0; b < NumBanks; b++) begin
      repeat (4) begin
        idx = b * BankWords + $urandom_range(BankWords - 1, 0);
        written.push_back(idx);
        write_word(name, idx, 8'hff, {$urandom(), $urandom()});
      end
    end
    foreach (written[i]) begin
      read_word(name, written[i]);
    end
    finish_test(name);
  endtask

  task automatic test_byte_enables();
    string name;
    name = "byte_enables";
    start_test();
    write_word(name, written[0], 8'b0101_1010, {$urandom(), $urandom()});
    write_word(name, written[5], 8'b1000_0001, {$urandom(), $urandom()});
    read_word(name, written[0]);
    read_word(name, written[5]);
    finish_test(name);
  endtask

  task automatic test_pipelined_reads();
    string       name;
    int unsigned idx [8];
    name = "pipelined_reads";
    start_test();
    for (int unsigned k = 0; k < 8; k++) begin
      idx[k] = written[2*k];
    end
    // Each response is due two edges after its request
    for (int unsigned c = 0; c < 9; c++) begin
      req_valid_i = (c < 8);
      req_i       = '0;
      if (c < 8) begin
        req_i.addr = word_addr(idx[c]);
      end
      step();
      if (c >= 1) begin
        check(name, 64'd1, 64'(rsp_valid_o));
        check(name, 64'd0, 64'(rsp_o.err));
        check(name, model[idx[c-1]], rsp_o.rdata);
      end else begin
        check(name, 64'd0, 64'(rsp_valid_o));
      end
    end
    step();
    check(name, 64'd0, 64'(rsp_valid_o));
    finish_test(name);
  endtask

  task automatic test_unmapped();
    string name;
    name = "unmapped";
    start_test();
    // Word 0 is where an out-of-window write would alias
    write_word(name, 0, 8'hff, 64'h0123_4567_89ab_cdef);
    expect_error(name, 1'b0, RamBase - 32'd8);
    expect_error(name, 1'b1, RamBase + AddrWidth'(Words * 8));
    check(name, 64'(err_expected), 64'(err_count_o));
    read_word(name, 0);
    finish_test(name);
  endtask

  task automatic test_ndmreset();
    string name;
    name = "ndmreset";
    start_test();
    ndmreset_i   = 1'b1;
    err_expected = 0;
    step();
    check(name, 64'(err_expected), 64'(err_count_o));
    check(name, 64'd1, 64'(debug_req_o));
    ndmreset_i = 1'b0;
    repeat (4) begin
      step();
      check(name, 64'd0, 64'(rsp_valid_o));
    end
    for (int unsigned i = 0; i < 4; i++) begin
      read_word(name, written[i]);
    end
    read_word(name, 0);
    debug_req_i = 1'b0;
    step();
    check(name, 64'd0, 64'(debug_req_o));
    debug_req_i = 1'b1;
    step();
    check(name, 64'd1, 64'(debug_req_o));
    finish_test(name);
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial begin
    void'($urandom(72));
    errors         = 0;
    test_errors    = 0;
    tests_run      = 0;
    tests_failed   = 0;
    err_expected   = 0;
    rst_ni         = 1'b0;
    ndmreset_i     = 1'b0;
    debug_enable_i = 1'b1;
    debug_req_i    = 1'b1;
    req_valid_i    = 1'b0;
    req_i          = '0;
    repeat (16) step();
    rst_ni = 1'b1;

    test_debug_holdoff();
    test_write_read();
    test_byte_enables();
    test_pipelined_reads();
    test_unmapped();
    test_ndmreset();

    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
